/* run_sim.sh */
#!/bin/sh
verilator --binary -f vlog.f --top-module tb_ex_top -o sim_ex > build.log 2>&1 \
    && ./obj_dir/sim_ex > sim.log 2>&1 \
    || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

/* src/ex_alu.sv */
module ex_alu (
    ex_ctrl_if.unit ctrl,
    input ex_bus_pkg::word_t reg1,
    input ex_bus_pkg::word_t reg2,
    input ex_bus_pkg::word_t imm,
    output ex_bus_pkg::word_t alu_result
);

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    word_t op_b;
    logic [SHAMT_W-1:0] shamt;
    logic lt_s;
    logic lt_u;
    logic do_sub;

    assign op_b = ctrl.use_imm ? imm : reg2;
    assign shamt = op_b[SHAMT_W-1:0];
    assign lt_s = $signed(reg1) < $signed(op_b);
    assign lt_u = reg1 < op_b;

    // bit 30 belongs to the immediate for addi, so sub is R form only
    assign do_sub = ctrl.alt && !ctrl.use_imm;

    always_comb begin
        case (ctrl.funct3)
            FUNCT3_ADD_SUB: begin
                alu_result = do_sub ? reg1 - op_b : reg1 + op_b;
            end
            FUNCT3_SLL: begin
                alu_result = reg1 << shamt;
            end
            FUNCT3_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_s};
            end
            FUNCT3_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_u};
            end
            FUNCT3_XOR: begin
                alu_result = reg1 ^ op_b;
            end
            FUNCT3_SRL_SRA: begin
                if (ctrl.alt) begin
                    // fill with the sign bit
                    alu_result = $signed(reg1) >>> shamt;
                end else begin
                    alu_result = reg1 >> shamt;
                end
            end
            FUNCT3_OR: begin
                alu_result = reg1 | op_b;
            end
            FUNCT3_AND: begin
                alu_result = reg1 & op_b;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

/* src/ex_branch.sv */
module ex_branch (
    ex_ctrl_if.unit ctrl,
    input ex_bus_pkg::addr_t pc,
    input ex_bus_pkg::word_t reg1,
    input ex_bus_pkg::word_t reg2,
    input ex_bus_pkg::word_t imm,
    output logic take,
    output ex_bus_pkg::addr_t target,
    output ex_bus_pkg::word_t link
);

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    logic cond;

    always_comb begin
        case (ctrl.funct3)
            FUNCT3_BEQ: cond = (reg1 == reg2);
            FUNCT3_BNE: cond = (reg1 != reg2);
            FUNCT3_BLT: cond = ($signed(reg1) < $signed(reg2));
            FUNCT3_BGE: cond = ($signed(reg1) >= $signed(reg2));
            FUNCT3_BLTU: cond = (reg1 < reg2);
            FUNCT3_BGEU: cond = (reg1 >= reg2);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.op_class)
            BRANCH: take = cond;
            JAL, JALR: take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.op_class == JALR) begin
            // target lsb is always cleared
            target = (reg1 + imm) & ~addr_t'(1);
        end else begin
            target = pc + imm;
        end
    end

    assign link = pc + INST_STEP;

endmodule

/* src/ex_bus_pkg.sv */
package ex_bus_pkg;

    // data and address widths
    localparam int XLEN = 32;
    localparam int ADDR_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTES_PER_WORD = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // one bit per byte lane
    typedef logic [BYTES_PER_WORD-1:0] byte_sel_t;

    // shift amount taken from the low operand bits
    localparam int SHAMT_W = 5;

    // link value is the next sequential pc
    localparam addr_t INST_STEP = 32'd4;

endpackage

/* src/ex_ctrl_if.sv */
interface ex_ctrl_if;

    import rv_isa_pkg::*;

    op_class_t op_class;
    funct3_t funct3;
    logic alt;
    // second alu operand comes from imm
    logic use_imm;

    modport dec (
        output op_class,
        output funct3,
        output alt,
        output use_imm
    );

    modport unit (
        input op_class,
        input funct3,
        input alt,
        input use_imm
    );

endinterface

/* src/ex_decode.sv */
module ex_decode (
    input ex_bus_pkg::word_t inst,
    ex_ctrl_if.dec ctrl
);

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    opcode_t opcode;
    funct7_t funct7;

    assign opcode = inst[OPCODE_LSB +: OPCODE_W];
    assign funct7 = inst[FUNCT7_LSB +: FUNCT7_W];

    assign ctrl.funct3 = inst[FUNCT3_LSB +: FUNCT3_W];
    assign ctrl.alt = inst[ALT_BIT];
    assign ctrl.use_imm = (opcode == OP_I);

    always_comb begin
        case (opcode)
            OP_R: begin
                // only the base and alternate funct7 are legal
                if (funct7 == FUNCT7_ZERO || funct7 == FUNCT7_ALT) begin
                    ctrl.op_class = ALU;
                end else begin
                    ctrl.op_class = NONE;
                end
            end
            OP_I: begin
                ctrl.op_class = ALU;
            end
            OP_S: begin
                ctrl.op_class = STORE;
            end
            OP_L: begin
                ctrl.op_class = LOAD;
            end
            OP_B: begin
                ctrl.op_class = BRANCH;
            end
            OP_LUI: begin
                ctrl.op_class = LUI;
            end
            OP_AUIPC: begin
                ctrl.op_class = AUIPC;
            end
            OP_JAL: begin
                ctrl.op_class = JAL;
            end
            OP_JALR: begin
                ctrl.op_class = JALR;
            end
            default: begin
                ctrl.op_class = NONE;
            end
        endcase
    end

endmodule

/* src/ex_lsu.sv */
module ex_lsu (
    ex_ctrl_if.unit ctrl,
    input ex_bus_pkg::word_t reg1,
    input ex_bus_pkg::word_t reg2,
    input ex_bus_pkg::word_t imm,
    input ex_bus_pkg::word_t ram_rdata,
    output logic ram_req,
    output logic ram_we,
    output ex_bus_pkg::byte_sel_t ram_sel,
    output ex_bus_pkg::addr_t ram_addr,
    output ex_bus_pkg::word_t ram_wdata,
    output ex_bus_pkg::word_t load_result
);

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    addr_t addr;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    logic half_ok;

    assign addr = reg1 + imm;

    // addressed byte and halfword of the read word
    assign rd_byte = ram_rdata[addr[1:0]*8 +: 8];
    assign rd_half = ram_rdata[addr[1]*16 +: 16];
    assign half_ok = (addr[0] == 1'b0);

    always_comb begin
        ram_req = 1'b0;
        ram_we = 1'b0;
        ram_sel = '0;
        ram_addr = '0;
        ram_wdata = '0;
        if (ctrl.op_class == STORE) begin
            case (ctrl.funct3)
                FUNCT3_SB: begin
                    ram_req = 1'b1;
                    ram_we = 1'b1;
                    ram_addr = addr;
                    ram_wdata = {4{reg2[7:0]}};
                    ram_sel = byte_sel_t'(1) << addr[1:0];
                end
                FUNCT3_SH: begin
                    ram_req = 1'b1;
                    ram_we = 1'b1;
                    ram_addr = addr;
                    ram_wdata = {2{reg2[15:0]}};
                    // misaligned half writes no lane
                    if (half_ok) begin
                        ram_sel = addr[1] ? 4'b1100 : 4'b0011;
                    end
                end
                FUNCT3_SW: begin
                    ram_req = 1'b1;
                    ram_we = 1'b1;
                    ram_addr = addr;
                    ram_wdata = reg2;
                    ram_sel = '1;
                end
                default: begin
                end
            endcase
        end else if (ctrl.op_class == LOAD) begin
            case (ctrl.funct3)
                FUNCT3_LB, FUNCT3_LH, FUNCT3_LW, FUNCT3_LBU, FUNCT3_LHU: begin
                    ram_req = 1'b1;
                    ram_addr = addr;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (ctrl.funct3)
            FUNCT3_LB: load_result = {{24{rd_byte[7]}}, rd_byte};
            FUNCT3_LBU: load_result = {24'h0, rd_byte};
            FUNCT3_LH: load_result = half_ok ? {{16{rd_half[15]}}, rd_half} : '0;
            FUNCT3_LHU: load_result = half_ok ? {16'h0, rd_half} : '0;
            FUNCT3_LW: load_result = ram_rdata;
            default: load_result = '0;
        endcase
    end

endmodule

/* src/ex_top.sv */
module ex_top (
    input logic clk,
    input logic arst_n,
    input ex_bus_pkg::addr_t pc,
    input ex_bus_pkg::word_t inst,
    input ex_bus_pkg::word_t reg1,
    input ex_bus_pkg::word_t reg2,
    input ex_bus_pkg::word_t imm,
    input ex_bus_pkg::reg_addr_t id_rd_addr,
    input logic id_rd_we,
    input ex_bus_pkg::word_t ram_rdata,
    output logic ram_req,
    output logic ram_we,
    output ex_bus_pkg::byte_sel_t ram_sel,
    output ex_bus_pkg::addr_t ram_addr,
    output ex_bus_pkg::word_t ram_wdata,
    output ex_bus_pkg::reg_addr_t rd_addr,
    output ex_bus_pkg::word_t rd_wdata,
    output logic rd_we,
    output logic jump_flag,
    output ex_bus_pkg::addr_t jump_addr
);

    import ex_bus_pkg::*;

    word_t alu_result;
    word_t load_result;
    word_t link;
    logic take;
    addr_t target;

    ex_ctrl_if ctrl ();

    ex_decode u_decode (
        .inst (inst),
        .ctrl (ctrl.dec)
    );

    ex_alu u_alu (
        .ctrl       (ctrl.unit),
        .reg1       (reg1),
        .reg2       (reg2),
        .imm        (imm),
        .alu_result (alu_result)
    );

    ex_branch u_branch (
        .ctrl   (ctrl.unit),
        .pc     (pc),
        .reg1   (reg1),
        .reg2   (reg2),
        .imm    (imm),
        .take   (take),
        .target (target),
        .link   (link)
    );

    // memory side stays combinational
    ex_lsu u_lsu (
        .ctrl        (ctrl.unit),
        .reg1        (reg1),
        .reg2        (reg2),
        .imm         (imm),
        .ram_rdata   (ram_rdata),
        .ram_req     (ram_req),
        .ram_we      (ram_we),
        .ram_sel     (ram_sel),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .load_result (load_result)
    );

    ex_writeback u_writeback (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl.unit),
        .pc          (pc),
        .imm         (imm),
        .id_rd_addr  (id_rd_addr),
        .id_rd_we    (id_rd_we),
        .alu_result  (alu_result),
        .load_result (load_result),
        .link        (link),
        .take        (take),
        .target      (target),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_we       (rd_we),
        .jump_flag   (jump_flag),
        .jump_addr   (jump_addr)
    );

endmodule

/* src/ex_writeback.sv */
module ex_writeback (
    input logic clk,
    input logic arst_n,
    ex_ctrl_if.unit ctrl,
    input ex_bus_pkg::addr_t pc,
    input ex_bus_pkg::word_t imm,
    input ex_bus_pkg::reg_addr_t id_rd_addr,
    input logic id_rd_we,
    input ex_bus_pkg::word_t alu_result,
    input ex_bus_pkg::word_t load_result,
    input ex_bus_pkg::word_t link,
    input logic take,
    input ex_bus_pkg::addr_t target,
    output ex_bus_pkg::reg_addr_t rd_addr,
    output ex_bus_pkg::word_t rd_wdata,
    output logic rd_we,
    output logic jump_flag,
    output ex_bus_pkg::addr_t jump_addr
);

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    word_t result;
    logic valid_op;

    assign valid_op = (ctrl.op_class != NONE);

    always_comb begin
        case (ctrl.op_class)
            ALU: result = alu_result;
            LUI: result = imm;
            AUIPC: result = pc + imm;
            LOAD: result = load_result;
            JAL, JALR: result = link;
            // store, branch and none write nothing useful
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr <= '0;
            rd_wdata <= '0;
            rd_we <= 1'b0;
            jump_flag <= 1'b0;
            jump_addr <= '0;
        end else begin
            rd_addr <= valid_op ? id_rd_addr : '0;
            rd_wdata <= result;
            rd_we <= id_rd_we && valid_op;
            jump_flag <= take;
            jump_addr <= take ? target : '0;
        end
    end

endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_W = 7;
    // selects sub and sra
    localparam int ALT_BIT = 30;

    localparam opcode_t OP_R = 7'b0110011;
    localparam opcode_t OP_I = 7'b0010011;
    localparam opcode_t OP_S = 7'b0100011;
    localparam opcode_t OP_L = 7'b0000011;
    localparam opcode_t OP_B = 7'b1100011;
    localparam opcode_t OP_LUI = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_JAL = 7'b1101111;
    localparam opcode_t OP_JALR = 7'b1100111;

    localparam funct7_t FUNCT7_ZERO = 7'b0000000;
    localparam funct7_t FUNCT7_ALT = 7'b0100000;

    // R and I forms share these
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL = 3'b001;
    localparam funct3_t FUNCT3_SLT = 3'b010;
    localparam funct3_t FUNCT3_SLTU = 3'b011;
    localparam funct3_t FUNCT3_XOR = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR = 3'b110;
    localparam funct3_t FUNCT3_AND = 3'b111;

    localparam funct3_t FUNCT3_BEQ = 3'b000;
    localparam funct3_t FUNCT3_BNE = 3'b001;
    localparam funct3_t FUNCT3_BLT = 3'b100;
    localparam funct3_t FUNCT3_BGE = 3'b101;
    localparam funct3_t FUNCT3_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BGEU = 3'b111;

    localparam funct3_t FUNCT3_SB = 3'b000;
    localparam funct3_t FUNCT3_SH = 3'b001;
    localparam funct3_t FUNCT3_SW = 3'b010;

    localparam funct3_t FUNCT3_LB = 3'b000;
    localparam funct3_t FUNCT3_LH = 3'b001;
    localparam funct3_t FUNCT3_LW = 3'b010;
    localparam funct3_t FUNCT3_LBU = 3'b100;
    localparam funct3_t FUNCT3_LHU = 3'b101;

    typedef enum logic [3:0] {
        ALU,
        LUI,
        AUIPC,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        NONE
    } op_class_t;

endpackage

/* test/tb_ex_vectors.svh */
// exec_row takes inst, reg1, reg2, imm, flags, rd_wdata and jump_addr
// flags are {id_we, rd_we, jump, req, mem_we}
// mem_row takes inst, reg1, reg2, imm, flags, rd_wdata, ram_sel and the memory word after the edge
// pc is 32'h100 and id_rd_addr is 5 on every row

// R form
exec_row(encode(7'h00, 3'd0, OP_R), 32'h7, 32'h5, 32'h0, 5'h18, 32'hc, 32'h0);
exec_row(encode(7'h20, 3'd0, OP_R), 32'h5, 32'h7, 32'h0, 5'h18, 32'hfffffffe, 32'h0);
exec_row(encode(7'h00, 3'd1, OP_R), 32'h3, 32'h24, 32'h0, 5'h18, 32'h30, 32'h0);
exec_row(encode(7'h00, 3'd2, OP_R), 32'hffffffff, 32'h1, 32'h0, 5'h18, 32'h1, 32'h0);
exec_row(encode(7'h00, 3'd3, OP_R), 32'hffffffff, 32'h1, 32'h0, 5'h18, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd4, OP_R), 32'hf0f0, 32'hff00, 32'h0, 5'h18, 32'h0ff0, 32'h0);
exec_row(encode(7'h00, 3'd5, OP_R), 32'h80000000, 32'h4, 32'h0, 5'h18, 32'h08000000, 32'h0);
exec_row(encode(7'h20, 3'd5, OP_R), 32'hf0000000, 32'h4, 32'h0, 5'h18, 32'hff000000, 32'h0);
exec_row(encode(7'h00, 3'd6, OP_R), 32'hf0, 32'h0f, 32'h0, 5'h00, 32'hff, 32'h0);
exec_row(encode(7'h00, 3'd7, OP_R), 32'hf0, 32'h3c, 32'h0, 5'h18, 32'h30, 32'h0);
// illegal funct7
exec_row(encode(7'h01, 3'd0, OP_R), 32'h7, 32'h5, 32'h0, 5'h10, 32'h0, 32'h0);
// I form
exec_row(encode(7'h7f, 3'd0, OP_I), 32'h10, 32'h0, 32'hfffffffc, 5'h18, 32'hc, 32'h0);
exec_row(encode(7'h20, 3'd5, OP_I), 32'h80000000, 32'h0, 32'h403, 5'h18, 32'hf0000000, 32'h0);
exec_row(encode(7'h00, 3'd2, OP_I), 32'hffffffff, 32'h0, 32'h1, 5'h18, 32'h1, 32'h0);
exec_row(encode(7'h7f, 3'd3, OP_I), 32'h1, 32'h0, 32'hffffffff, 5'h18, 32'h1, 32'h0);
// stores into word 4, then read back
mem_row(encode(7'h00, 3'd0, OP_S), 32'h10, 32'h11, 32'h0, 5'h03, 32'h0, 4'h1, 32'h8c9dae11);
mem_row(encode(7'h00, 3'd0, OP_S), 32'h10, 32'h22, 32'h1, 5'h03, 32'h0, 4'h2, 32'h8c9d2211);
mem_row(encode(7'h00, 3'd0, OP_S), 32'h10, 32'h33, 32'h2, 5'h03, 32'h0, 4'h4, 32'h8c332211);
mem_row(encode(7'h00, 3'd0, OP_S), 32'h10, 32'h44, 32'h3, 5'h03, 32'h0, 4'h8, 32'h44332211);
mem_row(encode(7'h00, 3'd1, OP_S), 32'h10, 32'h5566, 32'h0, 5'h03, 32'h0, 4'h3, 32'h44335566);
mem_row(encode(7'h00, 3'd1, OP_S), 32'h10, 32'h7788, 32'h2, 5'h03, 32'h0, 4'hc, 32'h77885566);
mem_row(encode(7'h00, 3'd1, OP_S), 32'h10, 32'h99aa, 32'h1, 5'h03, 32'h0, 4'h0, 32'h77885566);
mem_row(encode(7'h00, 3'd2, OP_L), 32'h10, 32'h0, 32'h0, 5'h1a, 32'h77885566, 4'h0, 32'h77885566);
mem_row(encode(7'h00, 3'd2, OP_S), 32'h14, 32'hdeadbeef, 32'h0, 5'h03, 32'h0, 4'hf, 32'hdeadbeef);
mem_row(encode(7'h00, 3'd2, OP_L), 32'h14, 32'h0, 32'h0, 5'h1a, 32'hdeadbeef, 4'h0, 32'hdeadbeef);
// loads from word 3
mem_row(encode(7'h00, 3'd0, OP_L), 32'hc, 32'h0, 32'h0, 5'h1a, 32'hffffffbe, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd0, OP_L), 32'hc, 32'h0, 32'h1, 5'h1a, 32'hffffffad, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd0, OP_L), 32'hc, 32'h0, 32'h2, 5'h1a, 32'hffffff9c, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd0, OP_L), 32'hc, 32'h0, 32'h3, 5'h1a, 32'hffffff8b, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd4, OP_L), 32'hc, 32'h0, 32'h0, 5'h1a, 32'hbe, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd4, OP_L), 32'hc, 32'h0, 32'h1, 5'h1a, 32'had, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd4, OP_L), 32'hc, 32'h0, 32'h2, 5'h1a, 32'h9c, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd4, OP_L), 32'hc, 32'h0, 32'h3, 5'h1a, 32'h8b, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd1, OP_L), 32'hc, 32'h0, 32'h0, 5'h1a, 32'hffffadbe, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd1, OP_L), 32'hc, 32'h0, 32'h2, 5'h1a, 32'hffff8b9c, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd1, OP_L), 32'hc, 32'h0, 32'h1, 5'h1a, 32'h0, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd5, OP_L), 32'hc, 32'h0, 32'h0, 5'h1a, 32'hadbe, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd5, OP_L), 32'hc, 32'h0, 32'h2, 5'h1a, 32'h8b9c, 4'h0, 32'h8b9cadbe);
mem_row(encode(7'h00, 3'd2, OP_L), 32'hc, 32'h0, 32'h0, 5'h1a, 32'h8b9cadbe, 4'h0, 32'h8b9cadbe);
// branches, taken then not taken
exec_row(encode(7'h00, 3'd0, OP_B), 32'h5, 32'h5, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd0, OP_B), 32'h5, 32'h6, 32'h40, 5'h00, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd1, OP_B), 32'h5, 32'h6, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd1, OP_B), 32'h5, 32'h5, 32'h40, 5'h00, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd4, OP_B), 32'hffffffff, 32'h1, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd4, OP_B), 32'h1, 32'hffffffff, 32'h40, 5'h00, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd5, OP_B), 32'h1, 32'hffffffff, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd5, OP_B), 32'hffffffff, 32'h1, 32'h40, 5'h00, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd6, OP_B), 32'h1, 32'hffffffff, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd6, OP_B), 32'hffffffff, 32'h1, 32'h40, 5'h00, 32'h0, 32'h0);
exec_row(encode(7'h00, 3'd7, OP_B), 32'hffffffff, 32'h1, 32'h40, 5'h04, 32'h0, 32'h140);
exec_row(encode(7'h00, 3'd7, OP_B), 32'h1, 32'hffffffff, 32'h40, 5'h00, 32'h0, 32'h0);
// jumps, upper immediates, undefined opcode
exec_row(encode(7'h00, 3'd0, OP_JAL), 32'h0, 32'h0, 32'h40, 5'h1c, 32'h104, 32'h140);
exec_row(encode(7'h00, 3'd0, OP_JALR), 32'h203, 32'h0, 32'h10, 5'h1c, 32'h104, 32'h212);
exec_row(encode(7'h00, 3'd0, OP_LUI), 32'h0, 32'h0, 32'h12345000, 5'h18, 32'h12345000, 32'h0);
exec_row(encode(7'h00, 3'd0, OP_AUIPC), 32'h0, 32'h0, 32'h1000, 5'h18, 32'h1100, 32'h0);
exec_row(encode(7'h7f, 3'd7, 7'h7f), 32'h10, 32'h4, 32'h8, 5'h10, 32'h0, 32'h0);

/* test/tb_ex_top.sv */
module tb_ex_top;

    import ex_bus_pkg::*;
    import rv_isa_pkg::*;

    typedef struct {
        word_t inst;
        word_t reg1;
        word_t reg2;
        word_t imm;
        logic [4:0] flags;
        word_t wdata;
        addr_t jaddr;
        byte_sel_t sel;
        word_t mem;
    } vec_t;

    logic clk = 1'b0;
    logic arst_n;
    addr_t pc;
    word_t inst;
    word_t reg1;
    word_t reg2;
    word_t imm;
    reg_addr_t id_rd_addr;
    logic id_rd_we;
    word_t ram_rdata;
    logic ram_req;
    logic ram_we;
    byte_sel_t ram_sel;
    addr_t ram_addr;
    word_t ram_wdata;
    reg_addr_t rd_addr;
    word_t rd_wdata;
    logic rd_we;
    logic jump_flag;
    addr_t jump_addr;

    word_t mem [16];
    vec_t vecs [$];
    int errors = 0;
    int tests_pass = 0;
    int tests_fail = 0;

    always #2 clk = ~clk;

    ex_top dut0 (.*);

    // 16-word memory, read combinationally, written by lane
    assign ram_rdata = mem[ram_addr[5:2]];

    always @(posedge clk) begin
        if (ram_req && ram_we) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_sel[b]) begin
                    mem[ram_addr[5:2]][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    function automatic word_t encode(input logic [6:0] f7, input logic [2:0] f3,
                                     input opcode_t op);
        return {f7, 10'h0, f3, 5'h0, op};
    endfunction

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // expected R form result
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_edge(input logic level);
        int guard;
        guard = 0;
        do begin
            @(clk);
            guard++;
        end while (clk !== level && guard < 4);
        if (clk !== level) begin
            $display("timeout while waiting for a clock edge");
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic drive(input word_t i, input word_t r1, input word_t r2,
                         input word_t im, input logic we);
        wait_edge(1'b0);
        inst = i;
        reg1 = r1;
        reg2 = r2;
        imm = im;
        id_rd_we = we;
    endtask

    task automatic exec_row(input word_t i, input word_t r1, input word_t r2, input word_t im,
                            input logic [4:0] fl, input word_t wd, input addr_t ja);
        vec_t v;
        v = '{i, r1, r2, im, fl, wd, ja, 4'h0, 32'h0};
        vecs.push_back(v);
    endtask

    task automatic mem_row(input word_t i, input word_t r1, input word_t r2, input word_t im,
                           input logic [4:0] fl, input word_t wd, input byte_sel_t sel,
                           input word_t mw);
        vec_t v;
        v = '{i, r1, r2, im, fl, wd, 32'h0, sel, mw};
        vecs.push_back(v);
    endtask

    task automatic load_vectors();
        `include "tb_ex_vectors.svh"
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_pass++;
            $display("test %s ok", name);
        end else begin
            tests_fail++;
            $display("test %s failed with %0d mismatches", name, errors - err_start);
        end
    endtask

    task automatic run_row(input int n);
        vec_t v;
        logic [3:0] idx;
        int err_start;
        v = vecs[n];
        err_start = errors;
        drive(v.inst, v.reg1, v.reg2, v.imm, v.flags[4]);
        #1;
        // registered outputs still show the previous row
        if (n > 0) begin
            check("held rd_wdata", rd_wdata, vecs[n-1].wdata);
            check("held jump_addr", jump_addr, vecs[n-1].jaddr);
        end
        check("ram_req", 32'(ram_req), 32'(v.flags[1]));
        check("ram_we", 32'(ram_we), 32'(v.flags[0]));
        check("ram_sel", 32'(ram_sel), 32'(v.sel));
        if (v.flags[1]) begin
            check("ram_addr", ram_addr, v.reg1 + v.imm);
        end
        idx = ram_addr[5:2];
        wait_edge(1'b1);
        #1;
        check("rd_wdata", rd_wdata, v.wdata);
        check("rd_we", 32'(rd_we), 32'(v.flags[3]));
        // a masked write enable marks an undefined instruction, which clears rd_addr
        check("rd_addr", 32'(rd_addr), (v.flags[4] && !v.flags[3]) ? 32'h0 : 32'(id_rd_addr));
        check("jump_flag", 32'(jump_flag), 32'(v.flags[2]));
        check("jump_addr", jump_addr, v.jaddr);
        if (v.flags[1]) begin
            check("memory word", mem[idx], v.mem);
        end
        report_test($sformatf("row %0d", n), err_start);
    endtask

    initial begin
        word_t rnd;
        word_t a;
        word_t b;
        logic [2:0] f3;
        logic alt;
        int err_start;
        arst_n = 1'b0;
        pc = 32'h100;
        inst = '0;
        reg1 = '0;
        reg2 = '0;
        imm = '0;
        id_rd_addr = 5'd5;
        id_rd_we = 1'b0;
        // every byte has its top bit set
        for (int i = 0; i < 16; i++) begin
            mem[i] <= 32'h8899_aabb + 32'h0101_0101 * 32'(i);
        end
        load_vectors();
        repeat (10) wait_edge(1'b1);
        wait_edge(1'b0);
        arst_n = 1'b1;
        #1;
        err_start = errors;
        check("reset rd_we", 32'(rd_we), 32'h0);
        check("reset jump_flag", 32'(jump_flag), 32'h0);
        check("reset jump_addr", jump_addr, 32'h0);
        check("reset rd_wdata", rd_wdata, 32'h0);
        check("reset rd_addr", 32'(rd_addr), 32'h0);
        report_test("reset", err_start);

        for (int n = 0; n < vecs.size(); n++) begin
            run_row(n);
        end

        err_start = errors;
        rnd = 32'h5d93_60fe;
        for (int n = 0; n < 200; n++) begin
            rnd = xorshift(rnd);
            a = rnd;
            rnd = xorshift(rnd);
            b = rnd;
            rnd = xorshift(rnd);
            f3 = rnd[2:0];
            alt = rnd[3] && (f3 == 3'd0 || f3 == 3'd5);
            drive(encode(alt ? 7'h20 : 7'h00, f3, OP_R), a, b, 32'h0, 1'b1);
            id_rd_addr = rnd[8:4];
            wait_edge(1'b1);
            #1;
            check($sformatf("sweep %0d rd_wdata", n), rd_wdata, alu_model(f3, alt, a, b));
            check($sformatf("sweep %0d rd_we", n), 32'(rd_we), 32'h1);
            check($sformatf("sweep %0d rd_addr", n), 32'(rd_addr), 32'(id_rd_addr));
        end
        report_test("random alu sweep", err_start);

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (errors == 0 && tests_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // stops a run that never ends
    initial begin
        #20000;
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+test
src/ex_bus_pkg.sv
src/rv_isa_pkg.sv
src/ex_ctrl_if.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_lsu.sv
src/ex_writeback.sv
src/ex_top.sv
test/tb_ex_top.sv
